//--- hw/cardio_bnn_pkg.sv
package cardio_bnn_pkg;

    localparam int FEAT_CNT   = 19;
    localparam int FEAT_BITS  = 4;
    localparam int HIDDEN_CNT = 40;
    localparam int CLASS_CNT  = 3;

    // A score counts matching hidden neurons, so it spans 0 to HIDDEN_CNT
    localparam int SCORE_BITS = $clog2(HIDDEN_CNT + 1);
    localparam int CLASS_BITS = $clog2(CLASS_CNT);

    // Worst case neuron sum is +/- FEAT_CNT * 15, plus one bit for the sign
    localparam int HID_SUM_BITS = $clog2(FEAT_CNT * ((1 << FEAT_BITS) - 1) + 1) + 1;

    typedef logic [FEAT_CNT-1:0][FEAT_BITS-1:0] feat_rec_t;  // Feature i at bits 4i+3:4i
    typedef logic [HIDDEN_CNT-1:0] hidden_t;
    typedef logic [CLASS_BITS-1:0] class_idx_t;
    typedef logic [CLASS_CNT-1:0][SCORE_BITS-1:0] score_vec_t;

    typedef struct packed {
        logic    valid;
        hidden_t bits;
    } hid_beat_t;

    typedef struct packed {
        logic       valid;
        score_vec_t score;
    } score_beat_t;

    // Row n holds neuron n, bit i set means feature i is added, clear means subtracted
    localparam logic [FEAT_CNT-1:0] HID_WEIGHTS [HIDDEN_CNT] = '{
        // Neurons 0 to 9
        19'b011_1101_0001_1010_1011,
        19'b010_1110_0100_1010_1010,
        19'b001_0101_0010_0101_0001,
        19'b110_0101_1110_0011_0001,
        19'b011_0110_1101_1011_1010,
        19'b101_0010_0001_0001_1101,
        19'b100_0101_1011_0011_0001,
        19'b001_1001_0001_1110_1100,
        19'b011_1011_0101_1010_1011,
        19'b100_0101_0011_0101_0101,
        // Neurons 10 to 19
        19'b100_0000_0101_0010_0001,
        19'b101_0011_1111_1001_0001,
        19'b001_0000_0001_1001_1110,
        19'b000_0000_0011_0111_0100,
        19'b000_1111_0101_1000_1011,
        19'b111_0010_0000_1001_0101,
        19'b011_1010_0100_0010_1110,
        19'b111_0000_1101_1010_1010,
        19'b001_1111_1000_0011_1010,
        19'b100_0011_1000_1000_0101,
        // Neurons 20 to 29
        19'b110_1000_0000_1000_0001,
        19'b011_1001_0101_1100_1010,
        19'b100_1110_0010_0000_0100,
        19'b011_0000_0110_0011_0001,
        19'b111_0010_1110_1010_0010,
        19'b000_1001_0010_1101_0001,
        19'b100_0000_1111_0111_0100,
        19'b000_0111_0101_1110_1011,
        19'b111_1000_0101_1001_1110,
        19'b001_0110_0001_0110_1011,
        // Neurons 30 to 39
        19'b011_0100_0000_1100_0000,
        19'b101_0101_0101_1100_1110,
        19'b011_0101_1101_1011_1011,
        19'b001_0010_1000_0001_0100,
        19'b000_1100_1000_1100_0101,
        19'b111_1011_0100_0110_1001,
        19'b100_0001_0010_0011_0000,
        19'b110_0000_1110_1110_1100,
        19'b011_1010_1001_0000_1010,
        19'b000_0011_0111_1110_0100
    };

    // Row c holds class c, bit n set means hidden[n] counts, clear means its inverse counts
    localparam logic [HIDDEN_CNT-1:0] OUT_WEIGHTS [CLASS_CNT] = '{
        40'b0100_1011_0011_1001_0011_0111_0110_0001_1011_0011,
        40'b1100_1011_0001_1011_0011_0111_0110_1001_1010_0111,
        40'b1010_1000_0001_1111_0000_0011_0010_0010_0011_1001
    };

endpackage

//--- hw/bnn_hidden_layer.sv
`timescale 1ns/1ps

module bnn_hidden_layer
    import cardio_bnn_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      feat_valid,
    input  feat_rec_t features,
    output hid_beat_t hid
);

    logic signed [HID_SUM_BITS-1:0] sums [HIDDEN_CNT];
    hidden_t hid_next;
    hidden_t bits_q;
    logic    valid_q;

    // Signed sum of all features, each taken with the sign from its weight bit
    function automatic logic signed [HID_SUM_BITS-1:0] neuron_sum(
        input feat_rec_t           f,
        input logic [FEAT_CNT-1:0] w
    );
        logic signed [HID_SUM_BITS-1:0] acc;
        logic signed [HID_SUM_BITS-1:0] term;
        acc = '0;
        for (int i = 0; i < FEAT_CNT; i++) begin
            term = $signed(HID_SUM_BITS'(f[i]));  // Features are unsigned
            if (w[i]) begin
                acc = acc + term;
            end else begin
                acc = acc - term;
            end
        end
        return acc;
    endfunction

    for (genvar n = 0; n < HIDDEN_CNT; n++) begin : g_neuron
        assign sums[n] = neuron_sum(features, HID_WEIGHTS[n]);

        // Fires on a sum of zero or more, i.e. a clear sign bit
        assign hid_next[n] = ~sums[n][HID_SUM_BITS-1];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= feat_valid;
        end
    end

    always_ff @(posedge clk) begin
        bits_q <= hid_next;
    end

    assign hid = '{valid: valid_q, bits: bits_q};

    // A record that entered with known features leaves no unknown neuron bits
    a_hid_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        hid.valid |-> !$isunknown(hid.bits)
    );

endmodule

//--- hw/bnn_class_scores.sv
`timescale 1ns/1ps

module bnn_class_scores
    import cardio_bnn_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  hid_beat_t   hid,
    output score_beat_t scores
);

    score_vec_t score_next;
    score_vec_t score_q;
    logic       valid_q;

    // Popcount of the positions where the hidden bit agrees with the class weight
    function automatic logic [SCORE_BITS-1:0] match_count(
        input hidden_t h,
        input hidden_t w
    );
        hidden_t              eq;
        logic [SCORE_BITS-1:0] cnt;
        eq  = ~(h ^ w);
        cnt = '0;
        for (int n = 0; n < HIDDEN_CNT; n++) begin
            cnt = cnt + SCORE_BITS'(eq[n]);
        end
        return cnt;
    endfunction

    for (genvar c = 0; c < CLASS_CNT; c++) begin : g_class
        assign score_next[c] = match_count(hid.bits, OUT_WEIGHTS[c]);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= hid.valid;
        end
    end

    always_ff @(posedge clk) begin
        score_q <= score_next;
    end

    assign scores = '{valid: valid_q, score: score_q};

    for (genvar c = 0; c < CLASS_CNT; c++) begin : g_chk
        // Where two weight rows differ exactly one of the two classes gains the match
        a_score_pair: assert property (
            @(posedge clk) disable iff (!rst_n)
            scores.valid |->
                ((scores.score[c] + scores.score[(c + 1) % CLASS_CNT]
                  + $countones(OUT_WEIGHTS[c] ^ OUT_WEIGHTS[(c + 1) % CLASS_CNT])) % 2 == 0)
                && (scores.score[c] <= scores.score[(c + 1) % CLASS_CNT]
                    + $countones(OUT_WEIGHTS[c] ^ OUT_WEIGHTS[(c + 1) % CLASS_CNT]))
        );
    end

endmodule

//--- hw/bnn_argmax.sv
`timescale 1ns/1ps

module bnn_argmax
    import cardio_bnn_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  score_beat_t scores,
    output class_idx_t  prediction,
    output logic        pred_valid
);

    class_idx_t best;

    // Strict compare keeps the earlier class on a tie, so the lowest index wins
    always_comb begin
        best = '0;
        for (int c = 1; c < CLASS_CNT; c++) begin
            if (scores.score[c] > scores.score[best]) begin
                best = class_idx_t'(c);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prediction <= '0;
            pred_valid <= 1'b0;
        end else begin
            prediction <= best;
            pred_valid <= scores.valid;  // Result strobe trails the score strobe by one cycle
        end
    end

    for (genvar c = 0; c < CLASS_CNT; c++) begin : g_chk
        // No class outscores the winner, and a lower class never ties it
        a_best_max: assert property (
            @(posedge clk) disable iff (!rst_n)
            scores.valid |-> (scores.score[best] >= scores.score[c])
                && (c >= best || scores.score[best] > scores.score[c])
        );
    end

endmodule

//--- hw/cardio_bnn_top.sv
`timescale 1ns/1ps

// Three registered stages, so a record strobed at edge k is reported after edge k+2
module cardio_bnn_top
    import cardio_bnn_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       feat_valid,
    input  feat_rec_t  features,
    output class_idx_t prediction,
    output logic       pred_valid
);

    hid_beat_t   hid;
    score_beat_t scores;

    bnn_hidden_layer bnn_hidden_layer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .feat_valid (feat_valid),
        .features   (features),
        .hid        (hid)
    );

    bnn_class_scores bnn_class_scores_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .hid    (hid),
        .scores (scores)
    );

    bnn_argmax bnn_argmax_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .scores     (scores),
        .prediction (prediction),
        .pred_valid (pred_valid)
    );

endmodule

//--- tb/cardio_bnn_vectors.svh
`ifndef CARDIO_BNN_VECTORS_SVH
`define CARDIO_BNN_VECTORS_SVH

// Columns are test name, feature record and expected class
// Feature i sits at bits 4i+3:4i of the record, so feature 0 is the rightmost nibble

typedef struct packed {
    feat_rec_t  features;
    class_idx_t expected;
} dir_vec_t;

localparam int VEC_CNT = 5;

string vec_name [VEC_CNT] = '{
    "all_zero",
    "all_fifteen",
    "feature0_only",
    "feature18_only",
    "features_0_and_18"
};

// Class scores in the comments are listed as class 0, 1, 2
localparam dir_vec_t VEC_TAB [VEC_CNT] = '{
    '{features: '0, expected: 2'd1},  // Every neuron fires, scores 21 23 16

    // A neuron fires when ten or more of its weights are +1, scores 27 25 26
    '{features: {FEAT_CNT{4'hf}}, expected: 2'd0},

    '{features: 76'hf, expected: 2'd1},  // Neuron bit follows weight bit 0, scores 17 19 18

    // Neuron bit follows weight bit 18, scores 13 13 24
    '{features: {4'hf, 72'h0}, expected: 2'd2},

    '{features: {4'hf, 68'h0, 4'hf}, expected: 2'd2}  // Fires unless both are -1, 15 17 20
};

`endif

//--- tb/cardio_bnn_tb.sv
`timescale 1ns/1ps

module cardio_bnn_tb
    import cardio_bnn_pkg::*;
();

    `include "cardio_bnn_vectors.svh"

    localparam int CLK_NS       = 40;
    localparam int RAND_CNT     = 200;
    localparam int GAP_CNT      = 150;
    localparam int INFLIGHT_CNT = 3;
    localparam int TOTAL_RECS   = VEC_CNT + 1 + RAND_CNT + GAP_CNT + INFLIGHT_CNT;
    localparam int WATCHDOG_NS  = (TOTAL_RECS + 20) * 3 * CLK_NS;

    // One record waiting for its result at the output
    typedef struct packed {
        class_idx_t cls;
        int         due;
        int         idx;
    } pend_t;

    logic       clk;
    logic       rst_n;
    logic       feat_valid;
    feat_rec_t  features;
    class_idx_t prediction;
    logic       pred_valid;

    pend_t pend_q [$];
    string cur_test = "startup";
    int    seed;
    int    cyc = 0;
    int    err_cnt = 0;
    int    err_at_start = 0;
    int    pass_cnt = 0;
    int    fail_cnt = 0;
    int    strobe_cnt = 0;
    int    pulse_cnt = 0;

    cardio_bnn_top cardio_bnn_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .feat_valid (feat_valid),
        .features   (features),
        .prediction (prediction),
        .pred_valid (pred_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Expected class straight from the network rules
    function automatic class_idx_t predict_class(input feat_rec_t f);
        int      sum;
        hidden_t h;
        int      score [CLASS_CNT];
        int      best;
        for (int n = 0; n < HIDDEN_CNT; n++) begin
            sum = 0;
            for (int i = 0; i < FEAT_CNT; i++) begin
                if (HID_WEIGHTS[n][i]) begin
                    sum = sum + int'(f[i]);
                end else begin
                    sum = sum - int'(f[i]);
                end
            end
            h[n] = (sum >= 0);
        end
        for (int c = 0; c < CLASS_CNT; c++) begin
            score[c] = 0;
            for (int n = 0; n < HIDDEN_CNT; n++) begin
                if (h[n] == OUT_WEIGHTS[c][n]) begin
                    score[c] = score[c] + 1;
                end
            end
        end
        best = 0;
        for (int c = 1; c < CLASS_CNT; c++) begin
            if (score[c] > score[best]) begin
                best = c;  // Ties keep the lower index
            end
        end
        return class_idx_t'(best);
    endfunction

    // With all features zero every neuron fires, so each score is a row popcount
    function automatic class_idx_t zero_record_class();
        int ones [CLASS_CNT];
        int best;
        best = 0;
        for (int c = 0; c < CLASS_CNT; c++) begin
            ones[c] = $countones(OUT_WEIGHTS[c]);
        end
        for (int c = 1; c < CLASS_CNT; c++) begin
            if (ones[c] > ones[best]) begin
                best = c;
            end
        end
        return class_idx_t'(best);
    endfunction

    function automatic feat_rec_t rand_record();
        logic [95:0] bits;
        bits = {$random(seed), $random(seed), $random(seed)};
        return bits[75:0];
    endfunction

    // Results are checked in arrival order against the records in flight
    always @(negedge clk) begin : monitor
        pend_t p;
        if (rst_n) begin
            if (pred_valid) begin
                pulse_cnt++;
                if (pend_q.size() == 0) begin
                    $display("%s: pred_valid pulsed at cycle %0d with no record in flight",
                             cur_test, cyc);
                    err_cnt++;
                end else begin
                    p = pend_q.pop_front();
                    if (p.due != cyc) begin
                        $display("** Error: %s record %0d: expected cycle %0d, actual cycle %0d",
                                 cur_test, p.idx, p.due, cyc);
                        err_cnt++;
                    end
                    if (prediction !== p.cls) begin
                        $display("** Error: %s record %0d: expected class %0d, actual class %0d",
                                 cur_test, p.idx, p.cls, prediction);
                        err_cnt++;
                    end
                end
            end else if (pend_q.size() != 0 && pend_q[0].due <= cyc) begin
                p = pend_q.pop_front();
                $display("%s record %0d: no pred_valid pulse arrived at cycle %0d",
                         cur_test, p.idx, p.due);
                err_cnt++;
            end
        end
    end

    task automatic begin_test(input string name);
        cur_test     = name;
        err_at_start = err_cnt;
        strobe_cnt   = 0;
        pulse_cnt    = 0;
    endtask

    task automatic finish_test();
        if (err_cnt == err_at_start) begin
            pass_cnt++;
            $display("%s: passed", cur_test);
        end else begin
            fail_cnt++;
            $display("%s: failed with %0d errors", cur_test, err_cnt - err_at_start);
        end
    endtask

    // The record enters on the next rising edge and shows up three edges later
    task automatic send_record(input feat_rec_t f, input class_idx_t cls);
        pend_t p;
        @(negedge clk);
        feat_valid = 1'b1;
        features   = f;
        p.cls = cls;
        p.due = cyc + 3;
        p.idx = strobe_cnt;
        pend_q.push_back(p);
        strobe_cnt++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            feat_valid = 1'b0;
        end
    endtask

    task automatic drain_pipeline();
        @(negedge clk);
        feat_valid = 1'b0;
        while (pend_q.size() != 0) begin
            @(negedge clk);
        end
        idle_cycles(2);  // Room for a stray extra pulse to show
    endtask

    task automatic compare_pulse_count();
        if (pulse_cnt != strobe_cnt) begin
            $display("%s: %0d records were strobed but %0d pred_valid pulses came out",
                     cur_test, strobe_cnt, pulse_cnt);
            err_cnt++;
        end
    endtask

    task automatic idle_after_reset();
        begin_test("reset_idle");
        if (prediction !== '0) begin
            $display("** Error: %s: expected prediction 0, actual %0d", cur_test, prediction);
            err_cnt++;
        end
        idle_cycles(10);
        finish_test();
    endtask

    task automatic zero_record();
        class_idx_t expected;
        class_idx_t model;
        begin_test("zero_record");
        expected = zero_record_class();
        model    = predict_class('0);
        if (model !== expected) begin
            $display("** Error: %s: expected class %0d, actual model class %0d",
                     cur_test, expected, model);
            err_cnt++;
        end
        send_record('0, expected);
        drain_pipeline();
        compare_pulse_count();
        finish_test();
    endtask

    task automatic apply_vector_table();
        class_idx_t model;
        for (int v = 0; v < VEC_CNT; v++) begin
            begin_test(vec_name[v]);
            model = predict_class(VEC_TAB[v].features);
            if (model !== VEC_TAB[v].expected) begin
                $display("** Error: %s: expected class %0d from table, actual model class %0d",
                         cur_test, VEC_TAB[v].expected, model);
                err_cnt++;
            end
            send_record(VEC_TAB[v].features, VEC_TAB[v].expected);
            drain_pipeline();
            compare_pulse_count();
            finish_test();
        end
    endtask

    task automatic back_to_back_stream();
        feat_rec_t f;
        begin_test("back_to_back");
        for (int k = 0; k < RAND_CNT; k++) begin
            f = rand_record();
            send_record(f, predict_class(f));
        end
        drain_pipeline();
        compare_pulse_count();
        finish_test();
    endtask

    task automatic gapped_stream();
        feat_rec_t   f;
        logic [31:0] r;
        begin_test("random_gaps");
        for (int k = 0; k < GAP_CNT; k++) begin
            f = rand_record();
            send_record(f, predict_class(f));
            r = $random(seed);
            idle_cycles(int'(r[1:0]));  // Gap of 0 to 3 idle cycles
        end
        drain_pipeline();
        compare_pulse_count();
        finish_test();
    endtask

    task automatic reset_mid_stream();
        feat_rec_t f;
        begin_test("reset_in_flight");
        for (int k = 0; k < 2; k++) begin
            f = rand_record();
            send_record(f, predict_class(f));
        end
        @(negedge clk);
        rst_n      = 1'b0;
        feat_valid = 1'b0;
        pend_q.delete();  // Records caught by the reset never come out
        for (int k = 0; k < 4; k++) begin
            @(negedge clk);
            if (pred_valid !== 1'b0) begin
                $display("%s: pred_valid was high during reset at cycle %0d", cur_test, cyc);
                err_cnt++;
            end
        end
        rst_n      = 1'b1;
        strobe_cnt = 0;
        pulse_cnt  = 0;
        idle_cycles(5);
        f = rand_record();
        send_record(f, predict_class(f));
        drain_pipeline();
        compare_pulse_count();
        finish_test();
    endtask

    initial begin
        seed       = 32'h820f_3704;
        rst_n      = 1'b0;
        feat_valid = 1'b0;
        features   = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        idle_after_reset();
        zero_record();
        apply_vector_table();
        back_to_back_stream();
        gapped_stream();
        reset_mid_stream();

        $display("Tests passed: %0d, tests failed: %0d, failed checks: %0d",
                 pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t in test %s, the run did not complete", $time, cur_test);
        $display("Errors found");
        $finish;
    end

endmodule

//--- files.f
+incdir+tb
hw/cardio_bnn_pkg.sv
hw/bnn_hidden_layer.sv
hw/bnn_class_scores.sv
hw/bnn_argmax.sv
hw/cardio_bnn_top.sv
tb/cardio_bnn_tb.sv
